// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = datapathTb
FILELIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== list.f ====
src/datapathPkg.sv
src/registerFile.sv
src/arithLogicUnit.sv
src/branchCondition.sv
src/memoryInterface.sv
src/datapath.sv
test/clockGen.sv
test/datapath_chk.sv
test/datapathTb.sv

// ==== src/arithLogicUnit.sv ====
/*
 * Arithmetic logic unit.
 * Combines Y with the bus word for the selected opcode; incPc turns it
 * into a plain increment of the bus word for the PC update.
 */
`timescale 1ns/1ps

module arithLogicUnit (
	input datapathPkg::word_t y,
	input datapathPkg::word_t b,
	input datapathPkg::aluOp_t op,
	input logic incPc,
	output datapathPkg::word_t result
);

	logic [4:0] shiftCount;

	assign shiftCount = b[4:0];

	always_comb begin
		if (incPc) begin
			result = b + 1'b1;
		end else begin
			case (op)
				datapathPkg::opAdd: begin
					result = y + b;
				end
				datapathPkg::opSub: begin
					result = y - b;
				end
				datapathPkg::opAnd: begin
					result = y & b;
				end
				datapathPkg::opOr: begin
					result = y | b;
				end
				datapathPkg::opShr: begin
					result = y >> shiftCount; // logical.
				end
				datapathPkg::opShl: begin
					result = y << shiftCount;
				end
				datapathPkg::opNeg: begin
					result = -b;
				end
				datapathPkg::opNot: begin
					result = ~b;
				end
				default: begin
					result = '0;
				end
			endcase
		end
	end

endmodule

// ==== src/branchCondition.sv ====
/*
 * Branch condition logic.
 * Tests the bus word against the C2 field of IR and keeps the CON flag.
 */
`timescale 1ns/1ps

module branchCondition (
	input logic Clock,
	input logic reset,
	input datapathPkg::word_t ir,
	input datapathPkg::word_t bus,
	input logic conIn,
	output logic conFlag
);

	datapathPkg::branchCond_t cond;
	logic taken;

	assign cond = datapathPkg::branchCond_t'(ir[datapathPkg::condMsb:datapathPkg::condLsb]);

	always_comb begin
		case (cond)
			datapathPkg::condZero: taken = (bus == '0);
			datapathPkg::condNonZero: taken = (bus != '0);
			datapathPkg::condPositive: taken = ~bus[datapathPkg::wordWidth-1];
			default: taken = bus[datapathPkg::wordWidth-1]; // brmi.
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			conFlag <= 1'b0;
		end else if (conIn) begin
			conFlag <= taken;
		end
	end

endmodule

// ==== src/datapath.sv ====
/*
 * Datapath top level.
 * Holds PC, IR, Y, Z and the I/O ports around a common bus; every step
 * is one control word from outside, with no control unit here.
 */
`timescale 1ns/1ps

module datapath (
	input logic Clock,
	input logic reset,
	input datapathPkg::controlWord_t control,
	input datapathPkg::word_t inPortData,
	output datapathPkg::word_t outPortData
);

	datapathPkg::word_t bus;
	datapathPkg::word_t pc;
	datapathPkg::word_t ir;
	datapathPkg::word_t y;
	datapathPkg::word_t z;
	datapathPkg::word_t inPort;
	datapathPkg::word_t outPort;
	datapathPkg::word_t regData;
	datapathPkg::word_t aluResult;
	datapathPkg::word_t mdrData;
	datapathPkg::word_t constC;
	logic conFlag;
	logic branchPending;

	registerFile regFile (
		.Clock(Clock),
		.reset(reset),
		.bus(bus),
		.ir(ir),
		.gra(control.gra),
		.grb(control.grb),
		.grc(control.grc),
		.rIn(control.rIn),
		.rOut(control.rOut),
		.baOut(control.baOut),
		.readData(regData)
	);

	arithLogicUnit alu (
		.y(y),
		.b(bus),
		.op(control.op),
		.incPc(control.incPc),
		.result(aluResult)
	);

	branchCondition branchCon (
		.Clock(Clock),
		.reset(reset),
		.ir(ir),
		.bus(bus),
		.conIn(control.conIn),
		.conFlag(conFlag)
	);

	memoryInterface memIf (
		.Clock(Clock),
		.reset(reset),
		.bus(bus),
		.marIn(control.marIn),
		.mdrIn(control.mdrIn),
		.read(control.read),
		.write(control.write),
		.mdrData(mdrData)
	);

	assign constC = {{(datapathPkg::wordWidth - datapathPkg::immWidth){ir[datapathPkg::immWidth-1]}},
		ir[datapathPkg::immWidth-1:0]};

	// one-hot AND-OR bus, zero when idle. regData is already gated by rOut/baOut.
	assign bus = regData
		| (pc & {datapathPkg::wordWidth{control.pcOut}})
		| (y & {datapathPkg::wordWidth{control.yOut}})
		| (z & {datapathPkg::wordWidth{control.zOut}})
		| (mdrData & {datapathPkg::wordWidth{control.mdrOut}})
		| (inPort & {datapathPkg::wordWidth{control.inPortOut}})
		| (constC & {datapathPkg::wordWidth{control.cOut}});

	always_ff @(posedge Clock) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
			y <= '0;
			z <= '0;
			outPort <= '0;
			branchPending <= 1'b0;
		end else begin
			if (control.irIn) ir <= bus;
			if (control.yIn) y <= bus;
			if (control.zIn) z <= aluResult;
			if (control.outPortIn) outPort <= bus;
			// a conIn step arms the next pcIn as conditional.
			if (control.pcIn) begin
				if (!branchPending || conFlag) pc <= bus;
				branchPending <= 1'b0;
			end else if (control.conIn) begin
				branchPending <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (control.inPortIn) begin
			inPort <= inPortData;
		end
	end

	assign outPortData = outPort;

endmodule

// ==== src/datapathPkg.sv ====
/*
 * Datapath package.
 * Shared widths, opcodes, branch conditions, the per-step control word
 * and instruction field positions for the bus-based RISC datapath.
 */
package datapathPkg;

	localparam int wordWidth = 32;
	localparam int regIndexWidth = 4;
	localparam int memAddrWidth = 9;
	localparam int numRegs = 16;
	localparam int memWords = 512;

	// instruction field positions.
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;
	localparam int raMsb = 26;
	localparam int raLsb = 23;
	localparam int rbMsb = 22;
	localparam int rbLsb = 19;
	localparam int rcMsb = 18;
	localparam int rcLsb = 15;
	localparam int immWidth = 19;
	localparam int condMsb = 20;
	localparam int condLsb = 19;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regIndexWidth-1:0] regIndex_t;
	typedef logic [memAddrWidth-1:0] memAddr_t;

	typedef enum logic [4:0] {
		opAdd = 5'b00011,
		opSub = 5'b00100,
		opShr = 5'b00101,
		opShl = 5'b00110,
		opAnd = 5'b01001,
		opOr = 5'b01010,
		opNeg = 5'b10000,
		opNot = 5'b10001,
		opBranch = 5'b10010
	} aluOp_t;

	typedef enum logic [1:0] {
		condZero = 2'b00,
		condNonZero = 2'b01,
		condPositive = 2'b10,
		condNegative = 2'b11
	} branchCond_t;

	// one step of strobes, applied at the next rising edge.
	typedef struct packed {
		logic read;
		logic write;
		logic incPc;
		logic gra;
		logic grb;
		logic grc;
		logic rIn;
		logic rOut;
		logic baOut;
		logic yIn;
		logic zIn;
		logic pcIn;
		logic irIn;
		logic marIn;
		logic mdrIn;
		logic inPortIn;
		logic outPortIn;
		logic conIn;
		logic yOut;
		logic zOut;
		logic pcOut;
		logic mdrOut;
		logic inPortOut;
		logic cOut;
		aluOp_t op;
	} controlWord_t;

endpackage

// ==== src/memoryInterface.sv ====
/*
 * Memory interface.
 * MAR and MDR in front of a 512-word memory; reads and writes take one cycle.
 */
`timescale 1ns/1ps

module memoryInterface (
	input logic Clock,
	input logic reset,
	input datapathPkg::word_t bus,
	input logic marIn,
	input logic mdrIn,
	input logic read,
	input logic write,
	output datapathPkg::word_t mdrData
);

	datapathPkg::word_t mem [datapathPkg::memWords];
	datapathPkg::memAddr_t mar;
	datapathPkg::word_t mdr;

	always_ff @(posedge Clock) begin
		if (reset) begin
			mar <= '0;
		end else if (marIn) begin
			mar <= bus[datapathPkg::memAddrWidth-1:0]; // word address only.
		end
	end

	// MDR source is memory on a read, the bus otherwise.
	always_ff @(posedge Clock) begin
		if (reset) begin
			mdr <= '0;
		end else if (mdrIn) begin
			if (read) begin
				mdr <= mem[mar];
			end else begin
				mdr <= bus;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (write) begin
			mem[mar] <= mdr;
		end
	end

	assign mdrData = mdr;

endmodule

// ==== src/registerFile.sv ====
/*
 * General register file.
 * Sixteen 32-bit registers addressed by the Ra, Rb or Rc field of IR.
 * Register 0 reads as zero when driven onto the bus through baOut.
 */
`timescale 1ns/1ps

module registerFile (
	input logic Clock,
	input logic reset,
	input datapathPkg::word_t bus,
	input datapathPkg::word_t ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	output datapathPkg::word_t readData
);

	datapathPkg::word_t regs [datapathPkg::numRegs];
	datapathPkg::regIndex_t sel;

	// select-and-encode.
	always_comb begin
		if (gra) begin
			sel = ir[datapathPkg::raMsb:datapathPkg::raLsb];
		end else if (grb) begin
			sel = ir[datapathPkg::rbMsb:datapathPkg::rbLsb];
		end else if (grc) begin
			sel = ir[datapathPkg::rcMsb:datapathPkg::rcLsb];
		end else begin
			sel = '0;
		end
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			for (int i = 0; i < datapathPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[sel] <= bus;
		end
	end

	// base-address read forces r0 to zero.
	always_comb begin
		if (baOut && sel == '0) begin
			readData = '0;
		end else if (rOut || baOut) begin
			readData = regs[sel];
		end else begin
			readData = '0; // not driving the bus.
		end
	end

endmodule

// ==== test/clockGen.sv ====
/*
 * Testbench clock and reset.
 * 20 ns clock, reset held high for the first two cycles.
 */
`timescale 1ns/1ps

module clockGen (
	output logic Clock,
	output logic reset
);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge Clock);
		#2 reset = 1'b0; // released just after the edge.
	end

endmodule

// ==== test/datapathTb.sv ====
/*
 * Datapath testbench.
 * Builds a table of control steps with expected output port values from a
 * small reference model, then applies it one step per clock.
 */
`timescale 1ns/1ps

module datapathTb;

	typedef struct packed {
		datapathPkg::controlWord_t cw;
		datapathPkg::word_t inData;
		logic check;
		datapathPkg::word_t expected;
		logic [2:0] testId;
	} step_t;

	logic Clock;
	logic reset;
	datapathPkg::controlWord_t control;
	datapathPkg::word_t inPortData;
	datapathPkg::word_t outPortData;
	step_t steps [$];
	logic [2:0] testId;
	logic [31:0] seed;
	datapathPkg::word_t modelPc;
	int errors;
	int checks;
	int testErrors;
	int testsFailed;
	string testNames [6];

	clockGen clockSource (.Clock(Clock), .reset(reset));

	datapath DUT (
		.Clock(Clock),
		.reset(reset),
		.control(control),
		.inPortData(inPortData),
		.outPortData(outPortData)
	);

	function automatic datapathPkg::word_t nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223; // lcg.
		return seed;
	endfunction

	function automatic datapathPkg::word_t aluModel(datapathPkg::aluOp_t op,
			datapathPkg::word_t a, datapathPkg::word_t b);
		case (op)
			datapathPkg::opAdd: return a + b;
			datapathPkg::opSub: return a - b;
			datapathPkg::opAnd: return a & b;
			datapathPkg::opOr: return a | b;
			datapathPkg::opShr: return a >> b[4:0];
			datapathPkg::opShl: return a << b[4:0];
			datapathPkg::opNeg: return 32'd0 - b;
			default: return ~b;
		endcase
	endfunction

	function automatic logic condHolds(logic [1:0] cond, datapathPkg::word_t v);
		case (cond)
			2'b00: return v == '0;
			2'b01: return v != '0;
			2'b10: return !v[31];
			default: return v[31];
		endcase
	endfunction

	task automatic addStep(datapathPkg::controlWord_t cw, datapathPkg::word_t inData,
			logic check = 1'b0, datapathPkg::word_t expected = '0);
		steps.push_back(step_t'{cw, inData, check, expected, testId});
	endtask

	task automatic checkOut(datapathPkg::controlWord_t cw, datapathPkg::word_t expected);
		cw.outPortIn = 1'b1;
		addStep(cw, '0, 1'b1, expected);
	endtask

	// latch a word in the input port, then drive it over the bus into the target.
	task automatic portMove(datapathPkg::word_t value, datapathPkg::controlWord_t cw);
		datapathPkg::controlWord_t latch;
		latch = '0;
		latch.inPortIn = 1'b1;
		addStep(latch, value);
		cw.inPortOut = 1'b1;
		addStep(cw, '0);
	endtask

	task automatic loadIr(datapathPkg::word_t word);
		datapathPkg::controlWord_t cw;
		cw = '0;
		cw.irIn = 1'b1;
		portMove(word, cw);
	endtask

	task automatic loadReg(datapathPkg::regIndex_t r, datapathPkg::word_t value);
		datapathPkg::controlWord_t cw;
		cw = '0;
		cw.gra = 1'b1;
		cw.rIn = 1'b1;
		loadIr({5'd0, r, 23'd0});
		portMove(value, cw);
	endtask

	task automatic storeWord(datapathPkg::word_t addr, datapathPkg::word_t data);
		datapathPkg::controlWord_t cw;
		cw = '0;
		cw.marIn = 1'b1;
		portMove(addr, cw);
		cw = '0;
		cw.mdrIn = 1'b1;
		portMove(data, cw);
		cw = '0;
		cw.write = 1'b1;
		addStep(cw, '0);
	endtask

	// T0 to T2 of every instruction.
	task automatic fetch();
		datapathPkg::controlWord_t cw;
		cw = '0;
		cw.pcOut = 1'b1;
		cw.marIn = 1'b1;
		cw.incPc = 1'b1;
		cw.zIn = 1'b1;
		addStep(cw, '0);
		cw = '0;
		cw.zOut = 1'b1;
		cw.pcIn = 1'b1;
		cw.read = 1'b1;
		cw.mdrIn = 1'b1;
		addStep(cw, '0);
		cw = '0;
		cw.mdrOut = 1'b1;
		cw.irIn = 1'b1;
		addStep(cw, '0);
	endtask

	task automatic registerTest();
		datapathPkg::controlWord_t cw;
		datapathPkg::word_t v;
		testId = 3'd0;
		v = nextRandom();
		loadReg(4'd7, v);
		cw = '0;
		cw.gra = 1'b1;
		cw.rOut = 1'b1;
		checkOut(cw, v);
		loadReg(4'd0, nextRandom());
		cw.rOut = 1'b0;
		cw.baOut = 1'b1;
		checkOut(cw, '0); // r0 reads as zero here.
	endtask

	task automatic aluTest();
		datapathPkg::aluOp_t ops [8];
		datapathPkg::controlWord_t cw;
		datapathPkg::word_t a;
		datapathPkg::word_t b;
		ops = '{datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd, datapathPkg::opOr,
			datapathPkg::opShr, datapathPkg::opShl, datapathPkg::opNeg, datapathPkg::opNot};
		testId = 3'd1;
		foreach (ops[k]) begin
			a = nextRandom();
			b = nextRandom();
			cw = '0;
			cw.yIn = 1'b1;
			portMove(a, cw);
			cw = '0;
			cw.zIn = 1'b1;
			cw.op = ops[k];
			portMove(b, cw);
			cw = '0;
			cw.zOut = 1'b1;
			checkOut(cw, aluModel(ops[k], a, b));
		end
	endtask

	task automatic memoryTest();
		datapathPkg::controlWord_t cw;
		datapathPkg::word_t r;
		datapathPkg::word_t d;
		testId = 3'd2;
		r = nextRandom();
		d = nextRandom();
		storeWord({23'd0, r[8:0]}, d);
		cw = '0;
		cw.mdrIn = 1'b1;
		portMove(~d, cw); // clobber MDR first.
		cw.read = 1'b1;
		addStep(cw, '0);
		cw = '0;
		cw.mdrOut = 1'b1;
		checkOut(cw, d);
	endtask

	task automatic fetchTest();
		datapathPkg::controlWord_t cw;
		datapathPkg::word_t v;
		testId = 3'd3;
		v = nextRandom();
		loadReg(4'd5, v);
		loadReg(4'd6, ~v);
		storeWord(modelPc, {datapathPkg::opAdd, 4'd5, 23'd0});
		fetch();
		modelPc = modelPc + 1;
		cw = '0;
		cw.pcOut = 1'b1;
		checkOut(cw, modelPc);
		cw = '0;
		cw.gra = 1'b1;
		cw.rOut = 1'b1;
		checkOut(cw, v);
	endtask

	task automatic branchTest();
		datapathPkg::controlWord_t cw;
		datapathPkg::word_t vals [3];
		datapathPkg::word_t r;
		logic [1:0] cond;
		testId = 3'd4;
		for (int c = 0; c < 4; c++) begin
			cond = c[1:0];
			r = nextRandom();
			vals[0] = '0;
			vals[1] = {1'b0, r[30:1], 1'b1};
			vals[2] = {1'b1, r[30:0]};
			foreach (vals[k]) begin
				loadReg(4'd2, vals[k]);
				storeWord(modelPc, {datapathPkg::opBranch, 4'd2, 2'b00, cond, 19'd35});
				fetch();
				cw = '0;
				cw.gra = 1'b1;
				cw.rOut = 1'b1;
				cw.conIn = 1'b1;
				addStep(cw, '0);
				cw = '0;
				cw.pcOut = 1'b1;
				cw.yIn = 1'b1;
				addStep(cw, '0);
				cw = '0;
				cw.cOut = 1'b1;
				cw.zIn = 1'b1;
				cw.op = datapathPkg::opAdd;
				addStep(cw, '0);
				cw = '0;
				cw.zOut = 1'b1;
				cw.pcIn = 1'b1;
				addStep(cw, '0);
				modelPc = modelPc + 1;
				if (condHolds(cond, vals[k])) begin
					modelPc = modelPc + 35;
				end
				cw = '0;
				cw.pcOut = 1'b1;
				checkOut(cw, modelPc);
			end
		end
	endtask

	task automatic constantTest();
		datapathPkg::controlWord_t cw;
		datapathPkg::word_t r;
		datapathPkg::word_t a;
		logic [18:0] c;
		testId = 3'd5;
		r = nextRandom();
		c = {1'b1, r[17:0]}; // always negative.
		a = nextRandom();
		loadIr({13'd0, c});
		cw = '0;
		cw.yIn = 1'b1;
		portMove(a, cw);
		cw = '0;
		cw.cOut = 1'b1;
		cw.zIn = 1'b1;
		cw.op = datapathPkg::opAdd;
		addStep(cw, '0);
		cw = '0;
		cw.zOut = 1'b1;
		checkOut(cw, a + {{13{c[18]}}, c});
	endtask

	task automatic runTable();
		for (int i = 0; i <= steps.size(); i++) begin
			@(posedge Clock);
			#2;
			if (i > 0 && steps[i-1].check) begin
				checks++;
				assert (outPortData == steps[i-1].expected) else begin
					$display("Error at %0d ns: %s step %0d output port %h, expected %h",
						$time, testNames[steps[i-1].testId], i - 1, outPortData,
						steps[i-1].expected);
					errors++;
					testErrors++;
				end
			end
			if (i > 0 && (i == steps.size() || steps[i].testId != steps[i-1].testId)) begin
				$display("test %s: %s", testNames[steps[i-1].testId],
					(testErrors == 0) ? "ok" : "FAILED");
				if (testErrors != 0) begin
					testsFailed++;
				end
				testErrors = 0;
			end
			if (i < steps.size()) begin
				control = steps[i].cw;
				inPortData = steps[i].inData;
			end else begin
				control = '0;
			end
		end
	endtask

	task automatic watchdog(int cycles);
		#((cycles + 20) * 20);
		$display("Timeout: the step table did not finish in time");
		$display("Test failures found");
		$finish;
	endtask

	initial begin
		control = '0;
		inPortData = '0;
		seed = 32'd82;
		modelPc = '0;
		errors = 0;
		checks = 0;
		testErrors = 0;
		testsFailed = 0;
		testNames = '{"register", "alu", "memory", "fetch", "branch", "constant"};
		registerTest();
		aluTest();
		memoryTest();
		fetchTest();
		branchTest();
		constantTest();
		fork
			watchdog(steps.size());
		join_none
		@(negedge reset);
		runTable();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", 6, testsFailed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== test/datapath_chk.sv ====
/*
 * Datapath checker.
 * Bus source exclusivity and hold behavior of the CON flag and PC.
 */
`timescale 1ns/1ps

module datapathChk (
	input logic Clock,
	input logic reset,
	input datapathPkg::controlWord_t control,
	input datapathPkg::word_t pc,
	input logic conFlag
);

	logic [6:0] sources;

	assign sources = {control.rOut | control.baOut, control.pcOut, control.yOut, control.zOut,
		control.mdrOut, control.inPortOut, control.cOut};

	busOneSource: assert property (@(posedge Clock) disable iff (reset) $onehot0(sources))
		else $error("more than one bus source enabled");

	conHeld: assert property (@(posedge Clock) disable iff (reset)
		!control.conIn |=> $stable(conFlag))
		else $error("CON changed without conIn");

	// PC may only move on a pcIn step.
	pcHeld: assert property (@(posedge Clock) disable iff (reset)
		!control.pcIn |=> $stable(pc))
		else $error("PC changed without pcIn");

endmodule

bind datapath datapathChk chk (.Clock(Clock), .reset(reset), .control(control), .pc(pc),
	.conFlag(conFlag));
